// ==== Makefile ====
# Verilator build of the float multiply testbench

BUILD = build

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module float_mul_tb \
		-f sources.f -Mdir $(BUILD) -o float_mul_sim

run: compile
	@out=$$(./$(BUILD)/float_mul_sim); \
	status=$$?; \
	echo "$$out"; \
	[ $$status -eq 0 ] && echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf $(BUILD)

// ==== rtl/float_mul_multicycle.sv ====
`timescale 1ns/1ns

module float_mul_multicycle #(
    parameter int bits_per_cycle = 2
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   req,
    output logic                   ack,
    input  float_pkg::float_word_u a,
    input  float_pkg::float_word_u b,
    output float_pkg::float_word_u out
);

    localparam int mw          = float_pkg::float_mant_width + 1;
    localparam int exp_w       = float_pkg::float_exp_width;
    localparam int pos_width   = $clog2(float_pkg::prod_width);
    localparam int carry_width = $clog2(mw + 1);
    // column index of the last group
    localparam int last_pos    = float_pkg::prod_width - bits_per_cycle;

    typedef enum logic [1:0] {
        st_idle,
        st_col_mul,
        st_normalize
    } state_t;

    state_t                                state;
    logic [pos_width-1:0]                  pos;

    logic [mw-1:0]                         a_mant;
    logic [mw-1:0]                         b_mant;
    logic                                  sign;
    logic [exp_w-1:0]                      exp;
    logic [float_pkg::prod_width-1:0]      prod;
    logic [carry_width-1:0]                carry;

    logic [carry_width-1:0]                carry_next;
    logic [bits_per_cycle-1:0]             step_bits;
    logic                                  op_zero;
    logic [exp_w-1:0]                      norm_exp;
    logic [float_pkg::float_mant_width-1:0] norm_mant;

    // any zero exponent field counts as zero
    assign op_zero = (a.fields.exp == '0) || (b.fields.exp == '0);

    mant_col_step #(
        .bits_per_cycle(bits_per_cycle)
    ) u_step (
        .pos       (pos),
        .a_mant    (a_mant),
        .b_mant    (b_mant),
        .carry_in  (carry),
        .prod_bits (step_bits),
        .carry_out (carry_next)
    );

    // 1.x * 1.y lands in [1, 4), so at most one right shift
    always_comb begin
        if (prod[float_pkg::prod_width-1]) begin
            norm_mant = prod[float_pkg::prod_width-2 -: float_pkg::float_mant_width];
            norm_exp  = exp + 1'b1;
        end else begin
            norm_mant = prod[float_pkg::prod_width-3 -: float_pkg::float_mant_width];
            norm_exp  = exp;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= st_idle;
            pos   <= '0;
            ack   <= 1'b0;
            out   <= '0;
        end else begin
            ack <= 1'b0;
            case (state)
                st_idle: begin
                    if (req) begin
                        if (op_zero) begin
                            // positive zero regardless of signs
                            out <= '0;
                            ack <= 1'b1;
                        end else begin
                            pos   <= '0;
                            state <= st_col_mul;
                        end
                    end
                end
                st_col_mul: begin
                    pos <= pos + pos_width'(bits_per_cycle);
                    if (pos == pos_width'(last_pos)) begin
                        state <= st_normalize;
                    end
                end
                st_normalize: begin
                    // truncated, no rounding
                    out.fields <= '{sign: sign, exp: norm_exp, mant: norm_mant};
                    ack        <= 1'b1;
                    state      <= st_idle;
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // operand and product datapath
    always_ff @(posedge clk) begin
        case (state)
            st_idle: begin
                if (req) begin
                    a_mant <= {1'b1, a.fields.mant};
                    b_mant <= {1'b1, b.fields.mant};
                    sign   <= a.fields.sign ^ b.fields.sign;
                    exp    <= exp_w'(a.fields.exp + b.fields.exp - float_pkg::float_bias);
                    carry  <= '0;
                end
            end
            st_col_mul: begin
                prod[pos +: bits_per_cycle] <= step_bits;
                carry                       <= carry_next;
            end
            default: begin
            end
        endcase
    end

endmodule

// ==== rtl/float_mul_top.sv ====
`timescale 1ns/1ns

module float_mul_top #(
    parameter int bits_per_cycle = 2
) (
    input  logic            clk,
    input  logic            rst,
    input  wb_pkg::wb_req_t wb_req,
    output wb_pkg::wb_rsp_t wb_rsp
);

    logic                   req;
    logic                   mul_ack;
    float_pkg::float_word_u a;
    float_pkg::float_word_u b;
    float_pkg::float_word_u mul_out;

    // host registers
    wb_float_mul_regs u_regs (
        .clk     (clk),
        .rst     (rst),
        .wb_req  (wb_req),
        .wb_rsp  (wb_rsp),
        .req     (req),
        .a       (a),
        .b       (b),
        .mul_ack (mul_ack),
        .mul_out (mul_out)
    );

    float_mul_multicycle #(
        .bits_per_cycle(bits_per_cycle)
    ) u_mul (
        .clk (clk),
        .rst (rst),
        .req (req),
        .ack (mul_ack),
        .a   (a),
        .b   (b),
        .out (mul_out)
    );

endmodule

// ==== rtl/float_pkg.sv ====
package float_pkg;

    // ieee 754 single precision layout
    localparam int float_width      = 32;
    localparam int float_exp_width  = 8;
    localparam int float_mant_width = 23;
    localparam int float_bias       = 127;

    // full product of two mantissas with hidden ones
    localparam int prod_width = 2 * (float_mant_width + 1);

    typedef struct packed {
        logic                        sign;
        logic [float_exp_width-1:0]  exp;
        logic [float_mant_width-1:0] mant;
    } float_t;

    // bus side sees raw, arithmetic side sees fields
    typedef union packed {
        logic [float_width-1:0] raw;
        float_t                 fields;
    } float_word_u;

endpackage

// ==== rtl/mant_col_step.sv ====
`timescale 1ns/1ns

module mant_col_step #(
    parameter int bits_per_cycle = 2
) (
    input  logic [$clog2(float_pkg::prod_width)-1:0]       pos,
    input  logic [float_pkg::float_mant_width:0]           a_mant,
    input  logic [float_pkg::float_mant_width:0]           b_mant,
    input  logic [$clog2(float_pkg::float_mant_width+2)-1:0] carry_in,
    output logic [bits_per_cycle-1:0]                      prod_bits,
    output logic [$clog2(float_pkg::float_mant_width+2)-1:0] carry_out
);

    localparam int mw = float_pkg::float_mant_width + 1;
    // a column holds at most mw pairs, so the carry stays at or below mw
    localparam int carry_width = $clog2(mw + 1);

    always_comb begin
        logic [carry_width:0]   sum;
        logic [carry_width-1:0] carry;
        int                     col;
        int                     j;

        carry = carry_in;
        for (int k = 0; k < bits_per_cycle; k++) begin
            col = int'(pos) + k;
            sum = {1'b0, carry};
            // every pair a[i] * b[j] with i + j == col
            for (int i = 0; i < mw; i++) begin
                j = col - i;
                if (j >= 0 && j < mw) begin
                    sum = sum + (a_mant[i] & b_mant[j]);
                end
            end
            prod_bits[k] = sum[0];
            carry = sum[carry_width:1];
        end
        carry_out = carry;
    end

endmodule

// ==== rtl/wb_float_mul_regs.sv ====
`timescale 1ns/1ns

module wb_float_mul_regs (
    input  logic                   clk,
    input  logic                   rst,
    input  wb_pkg::wb_req_t        wb_req,
    output wb_pkg::wb_rsp_t        wb_rsp,
    output logic                   req,
    output float_pkg::float_word_u a,
    output float_pkg::float_word_u b,
    input  logic                   mul_ack,
    input  float_pkg::float_word_u mul_out
);

    logic                              ack_q;
    logic [wb_pkg::wb_data_width-1:0]  dat_q;
    logic                              busy;
    logic                              done;
    float_pkg::float_word_u            result;

    logic                              active;
    logic                              wr;
    logic                              start;
    logic [wb_pkg::wb_data_width-1:0]  status;
    logic [wb_pkg::wb_data_width-1:0]  rd_data;

    assign active = wb_req.cyc && wb_req.stb;
    // write takes effect on the edge that ends the ack cycle
    assign wr     = active && wb_req.we && ack_q;
    assign start  = wr && (wb_req.adr == wb_pkg::reg_ctrl) && wb_req.dat[0] && !busy;

    always_comb begin
        status                    = '0;
        status[wb_pkg::stat_busy] = busy;
        status[wb_pkg::stat_done] = done;
    end

    always_comb begin
        case (wb_req.adr)
            wb_pkg::reg_opa:  rd_data = a.raw;
            wb_pkg::reg_opb:  rd_data = b.raw;
            wb_pkg::reg_ctrl: rd_data = status;
            default:          rd_data = result.raw;
        endcase
    end

    assign wb_rsp.ack = ack_q;
    assign wb_rsp.dat = dat_q;

    // fixed one cycle latency, ack never held for two cycles
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ack_q  <= 1'b0;
            req    <= 1'b0;
            busy   <= 1'b0;
            done   <= 1'b0;
            result <= '0;
        end else begin
            ack_q <= active && !ack_q;
            req   <= start;
            if (start) begin
                busy <= 1'b1;
                done <= 1'b0;
            end else if (mul_ack) begin
                busy   <= 1'b0;
                done   <= 1'b1;
                result <= mul_out;
            end
        end
    end

    // read data and operand storage
    always_ff @(posedge clk) begin
        if (active && !ack_q) begin
            dat_q <= rd_data;
        end
        // operands frozen while an operation runs
        if (wr && !busy) begin
            if (wb_req.adr == wb_pkg::reg_opa) begin
                a.raw <= wb_req.dat;
            end
            if (wb_req.adr == wb_pkg::reg_opb) begin
                b.raw <= wb_req.dat;
            end
        end
    end

endmodule

// ==== rtl/wb_pkg.sv ====
package wb_pkg;

    localparam int wb_data_width = 32;
    localparam int wb_adr_width  = 2;

    // master to slave
    typedef struct packed {
        logic                     cyc;
        logic                     stb;
        logic                     we;
        logic [wb_adr_width-1:0]  adr;
        logic [wb_data_width-1:0] dat;
    } wb_req_t;

    // slave to master
    typedef struct packed {
        logic                     ack;
        logic [wb_data_width-1:0] dat;
    } wb_rsp_t;

    // word indices
    localparam logic [wb_adr_width-1:0] reg_opa    = 2'd0;
    localparam logic [wb_adr_width-1:0] reg_opb    = 2'd1;
    localparam logic [wb_adr_width-1:0] reg_ctrl   = 2'd2;
    localparam logic [wb_adr_width-1:0] reg_result = 2'd3;

    // status bits read back at reg_ctrl
    localparam int stat_busy = 0;
    localparam int stat_done = 1;

endpackage

// ==== sim/float_mul_assertions.sv ====
`timescale 1ns/1ns

module float_mul_assertions (
    input logic            clk,
    input logic            rst,
    input wb_pkg::wb_req_t wb_req,
    input wb_pkg::wb_rsp_t wb_rsp,
    input logic            req,
    input logic            mul_ack,
    input logic            busy
);

    // read by the testbench at the end of the run
    int failures = 0;

    // ack answers an active request from the previous cycle
    wb_ack_after_request: assert property (@(posedge clk) disable iff (rst)
        wb_rsp.ack |-> $past(wb_req.cyc && wb_req.stb))
    else begin
        failures++;
        $error("wishbone ack without an active request");
    end

    wb_ack_single_cycle: assert property (@(posedge clk) disable iff (rst)
        wb_rsp.ack |=> !wb_rsp.ack)
    else begin
        failures++;
        $error("wishbone ack held for two cycles");
    end

    mul_ack_pulse: assert property (@(posedge clk) disable iff (rst)
        mul_ack |=> !mul_ack)
    else begin
        failures++;
        $error("multiplier ack longer than one cycle");
    end

    // start pulse only from an idle front end
    req_not_busy: assert property (@(posedge clk) disable iff (rst)
        $rose(req) |-> !$past(busy))
    else begin
        failures++;
        $error("multiplier request raised while busy");
    end

endmodule

// ==== sim/float_mul_tb.sv ====
`timescale 1ns/1ns

module float_mul_tb;

    localparam int normal_tests = 200;
    localparam int zero_tests   = 24;
    localparam int num_tests    = normal_tests + zero_tests + 2;
    localparam int cycle_limit  = num_tests * 60 + 100;

    logic            clk;
    logic            rst;
    wb_pkg::wb_req_t wb_req;
    wb_pkg::wb_rsp_t wb_rsp;
    integer          seed;
    int              cycles;

    float_mul_top DUT (
        .clk    (clk),
        .rst    (rst),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp)
    );

    bind float_mul_top float_mul_assertions u_checks (
        .clk     (clk),
        .rst     (rst),
        .wb_req  (wb_req),
        .wb_rsp  (wb_rsp),
        .req     (req),
        .mul_ack (mul_ack),
        .busy    (u_regs.busy)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Simulation FAILED");
            $fatal(1);
        end
    end

    task automatic check_float(input string name, input float_pkg::float_word_u expected,
                               input float_pkg::float_word_u got);
        if (got !== expected) begin
            $display("error at %0t: %s expected %h got %h", $time, name, expected.raw, got.raw);
            $display("Simulation FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_status(input string name, input logic [31:0] expected,
                                input logic [31:0] got);
        if (got !== expected) begin
            $display("error at %0t: %s expected %h got %h", $time, name, expected, got);
            $display("Simulation FAILED");
            $fatal(1);
        end
    endtask

    // hold the request until ack, release after the ack edge
    task automatic wb_cycle(input logic we, input logic [1:0] adr, input logic [31:0] dat,
                            output logic [31:0] rdat);
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = we;
        wb_req.adr = adr;
        wb_req.dat = dat;
        do begin
            @(posedge clk);
            #1;
        end while (!wb_rsp.ack);
        rdat = wb_rsp.dat;
        @(posedge clk);
        #1;
        wb_req = '0;
    endtask

    task automatic wb_write(input logic [1:0] adr, input logic [31:0] dat);
        logic [31:0] unused;
        wb_cycle(1'b1, adr, dat, unused);
    endtask

    task automatic wb_read(input logic [1:0] adr, output logic [31:0] dat);
        wb_cycle(1'b0, adr, '0, dat);
    endtask

    task automatic random_operand(input bit zero_exp, output float_pkg::float_word_u v);
        logic [31:0] r;
        logic [31:0] e;
        r = $random(seed);
        e = 64 + ({$random(seed)} % 127);
        v.fields.sign = r[31];
        v.fields.exp  = zero_exp ? 8'd0 : e[7:0];
        v.fields.mant = r[22:0];
    endtask

    // truncating product with zero exponent treated as zero
    function automatic float_pkg::float_word_u model_mul(input float_pkg::float_word_u a,
                                                         input float_pkg::float_word_u b);
        float_pkg::float_word_u res;
        logic [47:0]            p;
        int                     e;
        res = '0;
        if (a.fields.exp != '0 && b.fields.exp != '0) begin
            p = 48'({1'b1, a.fields.mant}) * 48'({1'b1, b.fields.mant});
            e = int'(a.fields.exp) + int'(b.fields.exp) - 127;
            res.fields.sign = a.fields.sign ^ b.fields.sign;
            if (p[47]) begin
                res.fields.mant = p[46:24];
                e = e + 1;
            end else begin
                res.fields.mant = p[45:23];
            end
            res.fields.exp = 8'(e);
        end
        return res;
    endfunction

    task automatic start_and_check_busy();
        logic [31:0] st;
        wb_write(wb_pkg::reg_ctrl, 32'h1);
        wb_read(wb_pkg::reg_ctrl, st);
        check_status("status after start", 32'(1) << wb_pkg::stat_busy, st);
    endtask

    task automatic wait_done();
        logic [31:0] st;
        do begin
            wb_read(wb_pkg::reg_ctrl, st);
        end while (!st[wb_pkg::stat_done]);
        check_status("status after completion", 32'(1) << wb_pkg::stat_done, st);
    endtask

    task automatic run_product(input float_pkg::float_word_u a, input float_pkg::float_word_u b);
        logic [31:0] r;
        wb_write(wb_pkg::reg_opa, a.raw);
        wb_write(wb_pkg::reg_opb, b.raw);
        start_and_check_busy();
        wait_done();
        wb_read(wb_pkg::reg_result, r);
        check_float("result", model_mul(a, b), r);
    endtask

    initial begin
        float_pkg::float_word_u a;
        float_pkg::float_word_u b;
        float_pkg::float_word_u a2;
        float_pkg::float_word_u b2;
        logic [31:0]            rd;
        seed   = 6;
        cycles = 0;
        clk    = 1'b0;
        rst    = 1'b1;
        wb_req = '0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        wb_read(wb_pkg::reg_ctrl, rd);
        check_status("status after reset", '0, rd);

        for (int i = 0; i < normal_tests; i++) begin
            random_operand(1'b0, a);
            random_operand(1'b0, b);
            run_product(a, b);
        end

        // zero on a, on b, then on both, with negative signs
        for (int i = 0; i < zero_tests; i++) begin
            random_operand(i % 3 != 1, a);
            random_operand(i % 3 != 0, b);
            a.fields.sign = 1'b1;
            b.fields.sign = 1'b1;
            run_product(a, b);
        end

        // operand and start writes during an operation
        random_operand(1'b0, a);
        random_operand(1'b0, b);
        random_operand(1'b0, a2);
        random_operand(1'b0, b2);
        wb_write(wb_pkg::reg_opa, a.raw);
        wb_write(wb_pkg::reg_opb, b.raw);
        start_and_check_busy();
        wb_write(wb_pkg::reg_opa, a2.raw);
        wb_write(wb_pkg::reg_opb, b2.raw);
        wb_write(wb_pkg::reg_ctrl, 32'h1);
        wait_done();
        wb_read(wb_pkg::reg_result, rd);
        check_float("result after busy writes", model_mul(a, b), rd);
        wb_read(wb_pkg::reg_opa, rd);
        check_float("reg_opa after busy writes", a, rd);
        wb_read(wb_pkg::reg_opb, rd);
        check_float("reg_opb after busy writes", b, rd);

        // result held across operand writes
        wb_write(wb_pkg::reg_opa, a2.raw);
        wb_write(wb_pkg::reg_opb, b2.raw);
        wb_read(wb_pkg::reg_result, rd);
        check_float("result after operand writes", model_mul(a, b), rd);
        wb_read(wb_pkg::reg_ctrl, rd);
        check_status("status after operand writes", 32'(1) << wb_pkg::stat_done, rd);

        if (DUT.u_checks.failures == 0) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            $display("%0d handshake assertions failed", DUT.u_checks.failures);
            $display("Simulation FAILED");
            $fatal(1);
        end
    end

endmodule

// ==== sources.f ====
rtl/float_pkg.sv
rtl/wb_pkg.sv
rtl/mant_col_step.sv
rtl/float_mul_multicycle.sv
rtl/wb_float_mul_regs.sv
rtl/float_mul_top.sv
sim/float_mul_assertions.sv
sim/float_mul_tb.sv
